// File: source/gpio_config.svh
// GPIO build constants
// Bus widths, register offset field and CTRL bit positions
`ifndef GPIO_CONFIG_SVH
`define GPIO_CONFIG_SVH

////////////////////////////////////////
// Bus and pin widths
////////////////////////////////////////
`define GPIO_DW 32  // Wishbone data bus
`define GPIO_AW 8   // Wishbone address bus
`define GPIO_GW 32  // Number of GPIO pins
`define GPIO_SW 4   // Byte selects

////////////////////////////////////////
// Address fields
////////////////////////////////////////
// Register offset sits in bits 4:2, all other address bits must be zero
`define GPIO_OFS_HI 4
`define GPIO_OFS_LO 2

// CTRL register bits
`define GPIO_CTRL_INTE 0  // Global interrupt enable
`define GPIO_CTRL_INTS 1  // Sticky interrupt flag

`endif

// File: source/gpio_pkg.sv
// GPIO shared types
// Register offsets, bus FSM states and vector types
`include "gpio_config.svh"

package gpio_pkg;

  // Register map, word offsets
  typedef enum logic [2:0] {
    REG_IN    = 3'd0,  // Synchronized pad inputs
    REG_OUT   = 3'd1,  // Pad output values
    REG_OE    = 3'd2,  // Output driver enables
    REG_INTE  = 3'd3,  // Per-pin interrupt enable
    REG_PTRIG = 3'd4,  // Trigger level, 1 = rising
    REG_AUX   = 3'd5,  // Aux input select
    REG_CTRL  = 3'd6,  // Global enable and flag
    REG_INTS  = 3'd7   // Sticky interrupt status
  } gpio_reg_e;

  // Wishbone slave transfer states
  typedef enum logic [1:0] {
    BUS_IDLE = 2'd0,  // Waiting for cyc & stb
    BUS_ACK  = 2'd1,  // Normal termination
    BUS_ERR  = 2'd2   // Decode error termination
  } bus_state_e;

  typedef logic [`GPIO_GW-1:0] gpio_vec_t;  // One bit per pin
  typedef logic [`GPIO_DW-1:0] wb_data_t;   // Data word
  typedef logic [`GPIO_SW-1:0] wb_sel_t;    // Byte lane selects

endpackage

// File: source/gpio_bus_ctrl.sv
// GPIO Wishbone slave control
// Full address decode, single cycle ack or err termination
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_bus_ctrl (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`GPIO_AW-1:0]   wb_adr_i,
  output logic                  wb_ack_o,   // Registered normal termination
  output logic                  wb_err_o,   // Registered error termination
  output logic                  reg_wr_o,   // Write strobe, valid address only
  output logic                  rd_load_o,  // Load read data register
  output gpio_pkg::gpio_reg_e   reg_sel_o   // Decoded register
);

  import gpio_pkg::*;

  bus_state_e state_q, state_d;
  logic       adr_ok;  // Address hits the register map
  logic       req;     // New transfer seen in idle

  // Word aligned and nothing above the offset field
  assign adr_ok = (wb_adr_i[`GPIO_OFS_LO-1:0] == '0) &&
                  (wb_adr_i[`GPIO_AW-1:`GPIO_OFS_HI+1] == '0);
  assign req    = wb_cyc_i & wb_stb_i & (state_q == BUS_IDLE);

  assign reg_sel_o = gpio_reg_e'(wb_adr_i[`GPIO_OFS_HI:`GPIO_OFS_LO]);
  assign reg_wr_o  = req & adr_ok & wb_we_i;   // Lands on the edge raising ack
  assign rd_load_o = req & adr_ok & ~wb_we_i;

  ////////////////////////////////////////
  // Transfer FSM
  ////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      BUS_IDLE: if (req) state_d = adr_ok ? BUS_ACK : BUS_ERR;
      BUS_ACK:  state_d = BUS_IDLE;  // Back to idle for one cycle
      BUS_ERR:  state_d = BUS_IDLE;
      default:  state_d = BUS_IDLE;
    endcase
  end

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) state_q <= BUS_IDLE;
    else          state_q <= state_d;
  end

  // Terminations straight from the state flops
  assign wb_ack_o = (state_q == BUS_ACK);
  assign wb_err_o = (state_q == BUS_ERR);

  // Only one kind of termination at a time
  a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    !(wb_ack_o && wb_err_o));

  // A termination never stretches past one cycle
  a_term_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o));

endmodule

// File: source/gpio_reg_file.sv
// GPIO register file
// OUT, OE, INTE, PTRIG and AUX with byte lanes, read data and pad outputs
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_reg_file (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 reg_wr_i,     // Write strobe from bus ctrl
  input  logic                 rd_load_i,    // Read data load strobe
  input  gpio_pkg::gpio_reg_e  reg_sel_i,
  input  gpio_pkg::wb_sel_t    wb_sel_i,
  input  gpio_pkg::wb_data_t   wb_dat_i,
  input  gpio_pkg::gpio_vec_t  pad_in_i,     // IN register
  input  logic [1:0]           ctrl_i,       // CTRL register
  input  gpio_pkg::gpio_vec_t  ints_i,       // INTS register
  input  gpio_pkg::gpio_vec_t  aux_i,        // Auxiliary pad sources
  output gpio_pkg::wb_data_t   wb_dat_o,
  output gpio_pkg::gpio_vec_t  ptrig_o,
  output gpio_pkg::gpio_vec_t  inte_o,
  output gpio_pkg::gpio_vec_t  ext_pad_o,
  output gpio_pkg::gpio_vec_t  ext_padoe_o
);

  import gpio_pkg::*;

  gpio_vec_t out_q, oe_q, inte_q, ptrig_q, aux_q;
  wb_data_t  rd_data;  // Read mux result

  // Replace only the byte lanes enabled in sel
  function automatic gpio_vec_t lane_merge(input gpio_vec_t cur,
                                           input wb_data_t  dat,
                                           input wb_sel_t   sel);
    gpio_vec_t res;
    res = cur;
    for (int b = 0; b < `GPIO_SW; b++) begin
      if (sel[b])
        res[b*8 +: 8] = dat[b*8 +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // Bus writable registers
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      out_q   <= '0;
      oe_q    <= '0;
      inte_q  <= '0;
      ptrig_q <= '0;
      aux_q   <= '0;
    end else if (reg_wr_i) begin
      case (reg_sel_i)
        REG_OUT:   out_q   <= lane_merge(out_q, wb_dat_i, wb_sel_i);
        REG_OE:    oe_q    <= lane_merge(oe_q, wb_dat_i, wb_sel_i);
        REG_INTE:  inte_q  <= lane_merge(inte_q, wb_dat_i, wb_sel_i);
        REG_PTRIG: ptrig_q <= lane_merge(ptrig_q, wb_dat_i, wb_sel_i);
        REG_AUX:   aux_q   <= lane_merge(aux_q, wb_dat_i, wb_sel_i);
        default: ;  // IN is read only, CTRL and INTS live in irq ctrl
      endcase
    end
  end

  ////////////////////////////////////////
  // Read path
  ////////////////////////////////////////
  always_comb begin
    case (reg_sel_i)
      REG_OUT:   rd_data = out_q;
      REG_OE:    rd_data = oe_q;
      REG_INTE:  rd_data = inte_q;
      REG_PTRIG: rd_data = ptrig_q;
      REG_AUX:   rd_data = aux_q;
      REG_CTRL:  rd_data = {{(`GPIO_DW-2){1'b0}}, ctrl_i};  // Two bits, zero fill
      REG_INTS:  rd_data = ints_i;
      default:   rd_data = pad_in_i;  // IN
    endcase
  end

  // Loaded on the request edge, valid through the ack cycle
  always_ff @(posedge wb_clk_i) begin
    if (rd_load_i)
      wb_dat_o <= rd_data;
  end

  assign ptrig_o = ptrig_q;
  assign inte_o  = inte_q;

  // AUX bit set hands the pin to aux_i
  assign ext_pad_o   = (out_q & ~aux_q) | (aux_i & aux_q);
  assign ext_padoe_o = oe_q;

endmodule

// File: source/gpio_input_sampler.sv
// GPIO input sampler
// Two-flop pad synchronizer, IN register and per-pin trigger detect
`timescale 1ns/10ps

module gpio_input_sampler (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  gpio_pkg::gpio_vec_t  ext_pad_i,  // Asynchronous pad inputs
  input  gpio_pkg::gpio_vec_t  ptrig_i,    // Trigger level per pin
  output gpio_pkg::gpio_vec_t  pad_in_o,   // IN register
  output gpio_pkg::gpio_vec_t  trig_o      // Pins about to reach PTRIG level
);

  import gpio_pkg::*;

  gpio_vec_t sync_q;  // First synchronizer stage
  gpio_vec_t pad_s;   // Second stage, safe to use
  gpio_vec_t in_q;

  ////////////////////////////////////////
  // Synchronizer and IN register
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      sync_q <= '0;
      pad_s  <= '0;
      in_q   <= '0;
    end else begin
      sync_q <= ext_pad_i;
      pad_s  <= sync_q;
      in_q   <= pad_s;  // Third edge after the pad change
    end
  end

  assign pad_in_o = in_q;

  // Changed and now equal to PTRIG, rising for 1 and falling for 0
  assign trig_o = (pad_s ^ in_q) & ~(pad_s ^ ptrig_i);

endmodule

// File: source/gpio_irq_ctrl.sv
// GPIO interrupt controller
// CTRL and INTS registers, registered interrupt request
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_irq_ctrl (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 reg_wr_i,
  input  gpio_pkg::gpio_reg_e  reg_sel_i,
  input  gpio_pkg::wb_data_t   wb_dat_i,
  input  gpio_pkg::gpio_vec_t  trig_i,     // Trigger hits from sampler
  input  gpio_pkg::gpio_vec_t  inte_i,     // Per-pin enables
  output logic [1:0]           ctrl_o,
  output gpio_pkg::gpio_vec_t  ints_o,
  output logic                 wb_inta_o
);

  import gpio_pkg::*;

  logic [1:0] ctrl_q;
  gpio_vec_t  ints_q;

  ////////////////////////////////////////
  // CTRL and INTS
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ctrl_q <= '0;
    end else if (reg_wr_i && reg_sel_i == REG_CTRL) begin
      ctrl_q <= wb_dat_i[1:0];
    end else if (ctrl_q[`GPIO_CTRL_INTE]) begin
      // Flag sticks once the request has been seen
      ctrl_q[`GPIO_CTRL_INTS] <= ctrl_q[`GPIO_CTRL_INTS] | wb_inta_o;
    end
  end

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ints_q <= '0;
    end else if (reg_wr_i && reg_sel_i == REG_INTS) begin
      ints_q <= wb_dat_i[`GPIO_GW-1:0];  // Bus write clears or sets
    end else if (ctrl_q[`GPIO_CTRL_INTE]) begin
      ints_q <= ints_q | (trig_i & inte_i);  // Same edge that updates IN
    end
  end

  // Request one edge behind INTS
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) wb_inta_o <= 1'b0;
    else          wb_inta_o <= (|ints_q) & ctrl_q[`GPIO_CTRL_INTE];
  end

  assign ctrl_o = ctrl_q;
  assign ints_o = ints_q;

  // No request unless the global enable was set a cycle earlier
  a_inta_needs_inte: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_inta_o |-> $past(ctrl_q[`GPIO_CTRL_INTE]));

endmodule

// File: source/gpio_top.sv
// Wishbone GPIO top level
// Bus control, register file, input sampler and interrupt controller
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_top (
  input  logic                 wb_clk_i,
  input  logic                 wb_rst_i,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [`GPIO_AW-1:0]  wb_adr_i,
  input  gpio_pkg::wb_sel_t    wb_sel_i,
  input  gpio_pkg::wb_data_t   wb_dat_i,
  output gpio_pkg::wb_data_t   wb_dat_o,
  output logic                 wb_ack_o,
  output logic                 wb_err_o,
  output logic                 wb_inta_o,
  input  gpio_pkg::gpio_vec_t  aux_i,        // Auxiliary pad sources
  input  gpio_pkg::gpio_vec_t  ext_pad_i,
  output gpio_pkg::gpio_vec_t  ext_pad_o,
  output gpio_pkg::gpio_vec_t  ext_padoe_o   // Active high driver enables
);

  import gpio_pkg::*;

  logic       reg_wr, rd_load;
  gpio_reg_e  reg_sel;
  gpio_vec_t  ptrig, inte;
  gpio_vec_t  pad_in, trig;  // Sampler results
  logic [1:0] ctrl;
  gpio_vec_t  ints;

  ////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////
  gpio_bus_ctrl u_bus_ctrl (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i,
    .wb_ack_o, .wb_err_o,
    .reg_wr_o (reg_wr), .rd_load_o (rd_load), .reg_sel_o (reg_sel)
  );

  gpio_reg_file u_reg_file (
    .wb_clk_i, .wb_rst_i,
    .reg_wr_i (reg_wr), .rd_load_i (rd_load), .reg_sel_i (reg_sel),
    .wb_sel_i, .wb_dat_i,
    .pad_in_i (pad_in), .ctrl_i (ctrl), .ints_i (ints), .aux_i,
    .wb_dat_o, .ptrig_o (ptrig), .inte_o (inte), .ext_pad_o, .ext_padoe_o
  );

  ////////////////////////////////////////
  // Pad side
  ////////////////////////////////////////
  gpio_input_sampler u_input_sampler (
    .wb_clk_i, .wb_rst_i, .ext_pad_i, .ptrig_i (ptrig),
    .pad_in_o (pad_in), .trig_o (trig)
  );

  gpio_irq_ctrl u_irq_ctrl (
    .wb_clk_i, .wb_rst_i, .reg_wr_i (reg_wr), .reg_sel_i (reg_sel), .wb_dat_i,
    .trig_i (trig), .inte_i (inte),
    .ctrl_o (ctrl), .ints_o (ints), .wb_inta_o
  );

endmodule

// File: bench/gpio_clk_gen.sv
// Testbench clock and reset
// 100 ns clock, reset held high for the first 4 cycles
`timescale 1ns/10ps

module gpio_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // Half period
  end

  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    rst_o <= 1'b0;  // Released on the fourth rising edge
  end

endmodule

// File: bench/gpio_tb.sv
// GPIO testbench
// Vector driven Wishbone master with pad, output and interrupt checks
`timescale 1ns/10ps
`include "gpio_config.svh"

module gpio_tb;

  import gpio_pkg::*;

  localparam int TIMEOUT = 32;  // Cycles allowed per wait

  logic                wb_clk_i, wb_rst_i;
  logic                wb_cyc_i, wb_stb_i, wb_we_i;
  logic [`GPIO_AW-1:0] wb_adr_i;
  wb_sel_t             wb_sel_i;
  wb_data_t            wb_dat_i, wb_dat_o;
  logic                wb_ack_o, wb_err_o, wb_inta_o;
  gpio_vec_t           aux_i, ext_pad_i, ext_pad_o, ext_padoe_o;
  logic [31:0]         lfsr;  // Idle gap source

  gpio_clk_gen u_clk_gen (.clk_o (wb_clk_i), .rst_o (wb_rst_i));

  gpio_top u_gpio_top (
    .wb_clk_i, .wb_rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i,
    .wb_sel_i, .wb_dat_i, .wb_dat_o, .wb_ack_o, .wb_err_o, .wb_inta_o,
    .aux_i, .ext_pad_i, .ext_pad_o, .ext_padoe_o
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  // Galois form with taps 32 30 26 25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "stopped on first mismatch");
    end
  endtask

  // 0 to 3 idle cycles with one LFSR step per bit
  task automatic idle_gap();
    int n;
    n = 0;
    for (int b = 0; b < 2; b++) begin
      if (lfsr[0]) n = n + (1 << b);
      lfsr = lfsr_next(lfsr);
    end
    repeat (n) @(posedge wb_clk_i);
  endtask

  // One classic cycle sampled on the falling edge
  task automatic bus_xfer(input logic we, input logic [`GPIO_AW-1:0] adr, input wb_sel_t sel,
                          input wb_data_t dat, input logic exp_err, output wb_data_t rdat);
    int n;
    n = 0;
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_sel_i <= sel;
    wb_dat_i <= dat;
    @(negedge wb_clk_i);
    while (!(wb_ack_o || wb_err_o) && n < TIMEOUT) begin
      n++;
      @(negedge wb_clk_i);
    end
    rdat = wb_dat_o;  // Valid during the ack cycle
    if (!(wb_ack_o || wb_err_o)) begin
      abort_run($sformatf("No ack or err came back for address %h", adr));
    end else begin
      check_eq({wb_ack_o, wb_err_o}, {~exp_err, exp_err}, $sformatf("{ack,err} at %h", adr));
      @(posedge wb_clk_i);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
    end
  endtask

  task automatic wait_inta(input logic lvl);
    int n;
    n = 0;
    @(negedge wb_clk_i);
    while (wb_inta_o !== lvl && n < TIMEOUT) begin
      n++;
      @(negedge wb_clk_i);
    end
    if (wb_inta_o !== lvl) abort_run("wb_inta_o never reached the expected level");
  endtask

  // Re-read until the value shows up since IN lags the pads
  task automatic poll_reg(input logic [`GPIO_AW-1:0] adr, input wb_data_t exp);
    wb_data_t rd;
    int       n;
    n = 0;
    bus_xfer(1'b0, adr, '1, '0, 1'b0, rd);
    while (rd !== exp && n < TIMEOUT) begin
      n++;
      bus_xfer(1'b0, adr, '1, '0, 1'b0, rd);
    end
    check_eq(rd, exp, $sformatf("polled read of %h", adr));
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    @(negedge wb_clk_i);
    while (wb_rst_i !== 1'b0 && n < TIMEOUT) begin
      n++;
      @(negedge wb_clk_i);
    end
    if (wb_rst_i !== 1'b0) abort_run("Reset was never released");
  endtask

  ////////////////////////////////////////
  // Vector interpreter
  ////////////////////////////////////////
  task automatic run_vectors(output int nvec);
    int                  fd, cnt;
    logic [8*128-1:0]    line;
    logic [3:0]          cmd, sel;
    logic [`GPIO_AW-1:0] adr;
    wb_data_t            dat, exp, rd;
    nvec = 0;
    fd = $fopen("bench/gpio_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open bench/gpio_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        cnt = $fgets(line, fd);
        // Comment and blank lines scan short
        if (cnt > 0 && $sscanf(line, "%h %h %h %h %h", cmd, adr, sel, dat, exp) == 5) begin
          nvec++;
          idle_gap();
          case (cmd)
            4'h1: bus_xfer(1'b1, adr, sel, dat, 1'b0, rd);
            4'h2: begin
              bus_xfer(1'b0, adr, sel, dat, 1'b0, rd);
              check_eq(rd, exp, $sformatf("read of %h", adr));
            end
            4'h3: bus_xfer(1'b1, adr, sel, dat, 1'b1, rd);
            4'h4: bus_xfer(1'b0, adr, sel, dat, 1'b1, rd);
            4'h5: begin
              @(posedge wb_clk_i);
              ext_pad_i <= dat;
            end
            4'h6: begin
              @(posedge wb_clk_i);
              aux_i <= dat;
            end
            4'h7: wait_inta(exp[0]);
            4'h8: begin
              @(negedge wb_clk_i);
              check_eq(ext_padoe_o, dat, "ext_padoe_o");
              check_eq(ext_pad_o, exp, "ext_pad_o");
            end
            4'h9: poll_reg(adr, exp);
            default: abort_run($sformatf("Unknown command %h in the vector file", cmd));
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int nvec;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_sel_i  = '0;
    wb_dat_i  = '0;
    aux_i     = '0;
    ext_pad_i = '0;
    lfsr      = 32'h4018db80;
    wait_reset_release();
    run_vectors(nvec);
    if (nvec == 0) begin
      $display("No vectors were found in bench/gpio_vectors.txt");
      $display("Simulation FAILED");
      $fatal(1, "nothing was run");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// File: gpio.f
+incdir+source
source/gpio_pkg.sv
source/gpio_bus_ctrl.sv
source/gpio_reg_file.sv
source/gpio_input_sampler.sv
source/gpio_irq_ctrl.sv
source/gpio_top.sv
bench/gpio_clk_gen.sv
bench/gpio_tb.sv

// File: Bender.yml
package:
  name: gpio

export_include_dirs:
  - source

sources:
  # RTL, package first
  - include_dirs:
      - source
    files:
      - source/gpio_pkg.sv
      - source/gpio_bus_ctrl.sv
      - source/gpio_reg_file.sv
      - source/gpio_input_sampler.sv
      - source/gpio_irq_ctrl.sv
      - source/gpio_top.sv
  # Testbench
  - target: test
    include_dirs:
      - source
    files:
      - bench/gpio_clk_gen.sv
      - bench/gpio_tb.sv

// File: bench/gpio_vectors.txt
// cmd adr sel data exp, hex. cmd 1 wr, 2 rd, 3 wr err, 4 rd err, 5 pads, 6 aux
// 7 wait inta == exp, 8 padoe == data and pad_o == exp, 9 poll rd until exp
// Reset values
2 00 f 00000000 00000000
2 04 f 00000000 00000000
2 08 f 00000000 00000000
2 0c f 00000000 00000000
2 10 f 00000000 00000000
2 14 f 00000000 00000000
2 18 f 00000000 00000000
2 1c f 00000000 00000000
8 00 0 00000000 00000000
7 00 0 00000000 00000000
// Byte lanes, IN write ignored
1 04 5 a1b2c3d4 00000000
1 04 2 55667788 00000000
2 04 f 00000000 00b277d4
1 08 c ffff0000 00000000
2 08 f 00000000 ffff0000
1 14 8 0f000000 00000000
2 14 f 00000000 0f000000
1 00 f ffffffff 00000000
2 00 f 00000000 00000000
6 00 0 ffffffff 00000000
8 00 0 ffff0000 0fb277d4
// Decode errors leave OUT alone
3 05 f 12345678 00000000
3 24 f 12345678 00000000
4 e8 f 00000000 00000000
2 04 f 00000000 00b277d4
// Pads and interrupts
5 00 0 000000a5 00000000
9 00 f 00000000 000000a5
1 0c f 0000000f 00000000
1 10 f 00000003 00000000
1 18 f 00000001 00000000
5 00 0 00000092 00000000
7 00 0 00000000 00000001
2 1c f 00000000 00000006
2 18 f 00000000 00000003
1 1c f 00000000 00000000
7 00 0 00000000 00000000
5 00 0 0000018a 00000000
9 00 f 00000000 0000018a
2 1c f 00000000 00000000
7 00 0 00000000 00000000
